//--- Bender.yml
package:
  name: rob_commit

sources:
  - logic/rob_pkg.sv
  - logic/rob_occupancy.sv
  - logic/rob_entry_store.sv
  - logic/commit_ctrl.sv
  - logic/rob_top.sv
  - target: test
    files:
      - testbench/rob_tb.sv

//--- filelist.f
logic/rob_pkg.sv
logic/rob_occupancy.sv
logic/rob_entry_store.sv
logic/commit_ctrl.sv
logic/rob_top.sv
testbench/rob_tb.sv

//--- logic/commit_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module commit_ctrl (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  rob_pkg::rob_entry_t     head_entry_i,
  input  logic                    empty_i,
  input  logic                    has_free_i,
  input  logic                    issue_valid_i,
  input  rob_pkg::flags_t         flag_i,
  output logic                    issue_ready_o,
  output logic                    issue_fire_o,
  output logic                    commit_o,
  output logic                    flush_o,
  output logic                    store_pop_o,
  output logic                    preg_free_o,
  output rob_pkg::preg_t          preg_free_num_o,
  output logic                    rename_valid_o,
  output rob_pkg::commit_rename_t rename_entry_o,
  output logic                    flag_valid_o,
  output rob_pkg::flag_update_t   flag_update_o,
  output logic                    mispredict_o,
  output rob_pkg::word_t          redirect_pc_o
);
  import rob_pkg::*;

  commit_state_e state_q;
  commit_state_e state_n;
  word_t         expected_pc_q;
  word_t         expected_pc_n;

  logic  head_ready;
  logic  cond_taken;
  word_t target_pc;

  // branch condition against the committed flags
  always_comb
  begin
    case (head_entry_i.info.bcc_op)
      EQ:      cond_taken = flag_i.z;
      NE:      cond_taken = ~flag_i.z;
      CS:      cond_taken = flag_i.c;
      CC:      cond_taken = ~flag_i.c;
      MI:      cond_taken = flag_i.n;
      PL:      cond_taken = ~flag_i.n;
      VS:      cond_taken = flag_i.v;
      VC:      cond_taken = ~flag_i.v;
      HI:      cond_taken = flag_i.c & ~flag_i.z;
      LS:      cond_taken = ~flag_i.c | flag_i.z;
      GE:      cond_taken = (flag_i.n == flag_i.v);
      LT:      cond_taken = (flag_i.n != flag_i.v);
      GT:      cond_taken = ~flag_i.z & (flag_i.n == flag_i.v);
      LE:      cond_taken = flag_i.z | (flag_i.n != flag_i.v);
      AL:      cond_taken = 1'b1;
      default: cond_taken = 1'b0;
    endcase
  end

  // where the instruction after this branch must come from
  always_comb
  begin
    if (!head_entry_i.info.is_cond_branch || cond_taken)
      target_pc = head_entry_i.resolved_pc;
    else
      target_pc = head_entry_i.info.pc + 1'b1;
  end

  assign head_ready   = head_entry_i.wb & ~empty_i;
  assign mispredict_o = (state_q == CS_CHECK_TARGET) & head_ready &
                        (head_entry_i.info.pc != expected_pc_q);
  assign flush_o      = mispredict_o;
  assign commit_o     = head_ready & ~mispredict_o;

  assign issue_ready_o = has_free_i & ~mispredict_o;
  assign issue_fire_o  = issue_valid_i & issue_ready_o;

  // commit side effects
  assign store_pop_o     = commit_o & head_entry_i.info.is_store;
  assign preg_free_o     = commit_o & head_entry_i.info.w_v & ~head_entry_i.info.is_store;
  assign preg_free_num_o = head_entry_i.info.freed_reg;
  assign rename_valid_o  = commit_o;
  assign rename_entry_o  = '{w_v:       head_entry_i.info.w_v,
                             alloc_reg: head_entry_i.info.alloc_reg,
                             freed_reg: head_entry_i.info.freed_reg};
  assign flag_valid_o    = commit_o & (|head_entry_i.info.flag_mask);
  assign flag_update_o   = '{mask:  head_entry_i.info.flag_mask,
                             value: head_entry_i.flags};
  assign redirect_pc_o   = expected_pc_q;

  always_comb
  begin
    state_n       = state_q;
    expected_pc_n = expected_pc_q;
    if (mispredict_o)
      state_n = CS_SEQUENTIAL;
    else if (commit_o)
    begin
      if (head_entry_i.info.is_spec)
      begin
        state_n       = CS_CHECK_TARGET;
        expected_pc_n = target_pc;
      end
      else
        state_n = CS_SEQUENTIAL;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_q       <= CS_SEQUENTIAL;
      expected_pc_q <= '0;
    end
    else
    begin
      state_q       <= state_n;
      expected_pc_q <= expected_pc_n;
    end
  end

  a_mispredict_state: assert property (@(posedge clk_i) disable iff (reset_i)
    mispredict_o |-> state_q == CS_CHECK_TARGET)
    else $error("mispredict outside target check");

  // the flush has to leave the buffer empty one cycle later
  a_flush_empties: assert property (@(posedge clk_i) disable iff (reset_i)
    mispredict_o |=> empty_i && state_q == CS_SEQUENTIAL)
    else $error("buffer not empty after flush");

endmodule

`default_nettype wire

//--- logic/rob_entry_store.sv
`timescale 1ns/10ps
`default_nettype none

module rob_entry_store #(
  parameter int NUM_ENTRIES = 8,
  parameter int NUM_FU      = 2
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  issue_fire_i,
  input  rob_pkg::issue_entry_t issue_entry_i,
  input  rob_pkg::rob_tag_t     alloc_tag_i,
  input  rob_pkg::cdb_t         cdb_i [NUM_FU],
  input  logic                  commit_i,
  input  rob_pkg::rob_tag_t     commit_tag_i,
  input  logic                  flush_i,
  output rob_pkg::rob_entry_t   head_entry_o
);
  import rob_pkg::*;

  localparam int PTR_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

  issue_entry_t           info_q        [NUM_ENTRIES];
  flags_t                 flags_q       [NUM_ENTRIES];
  word_t                  resolved_pc_q [NUM_ENTRIES];
  logic [NUM_ENTRIES-1:0] wb_q;

  // per slot writeback match and the lane that hit it
  logic [NUM_ENTRIES-1:0] cdb_hit;
  cdb_t                   cdb_sel [NUM_ENTRIES];

  logic [PTR_W-1:0] alloc_idx;
  logic [PTR_W-1:0] head_idx;

  assign alloc_idx = alloc_tag_i[PTR_W-1:0];
  assign head_idx  = commit_tag_i[PTR_W-1:0];

  // only slots still waiting for a result accept a lane
  always_comb
  begin
    cdb_hit = '0;
    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      cdb_sel[i] = '0;
      for (int j = 0; j < NUM_FU; j++)
      begin
        if (cdb_i[j].valid && !wb_q[i] && cdb_i[j].rob_tag == rob_tag_t'(i))
        begin
          cdb_hit[i] = 1'b1;
          cdb_sel[i] = cdb_i[j];
        end
      end
    end
  end

  // written-back bits, the only control state of the array
  always_ff @(posedge clk_i)
  begin
    if (reset_i || flush_i)
      wb_q <= '0;
    else
    begin
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
        if (cdb_hit[i])
          wb_q[i] <= 1'b1;
        if (commit_i && head_idx == PTR_W'(i))
          wb_q[i] <= 1'b0;
        if (issue_fire_i && alloc_idx == PTR_W'(i))
          wb_q[i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      if (issue_fire_i && alloc_idx == PTR_W'(i))
        info_q[i] <= issue_entry_i;
      if (cdb_hit[i])
      begin
        flags_q[i] <= cdb_sel[i].flags;
        // branch units return the target on the result field
        if (info_q[i].is_spec)
          resolved_pc_q[i] <= cdb_sel[i].result;
      end
    end
  end

  assign head_entry_o = '{info:        info_q[head_idx],
                          wb:          wb_q[head_idx],
                          flags:       flags_q[head_idx],
                          resolved_pc: resolved_pc_q[head_idx]};

  for (genvar j = 0; j < NUM_FU; j++)
  begin : g_cdb_check
    a_no_double_wb: assert property (@(posedge clk_i) disable iff (reset_i)
      cdb_i[j].valid && (cdb_i[j].rob_tag < NUM_ENTRIES)
      |-> !wb_q[cdb_i[j].rob_tag[PTR_W-1:0]])
      else $error("lane %0d writes slot %0h twice", j, cdb_i[j].rob_tag);
  end

endmodule

`default_nettype wire

//--- logic/rob_occupancy.sv
`timescale 1ns/10ps
`default_nettype none

module rob_occupancy #(
  parameter int NUM_ENTRIES = 8
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              issue_fire_i,
  input  logic              commit_i,
  input  logic              flush_i,
  output rob_pkg::rob_tag_t alloc_tag_o,
  output rob_pkg::rob_tag_t commit_tag_o,
  output logic              has_free_o,
  output logic              empty_o
);
  import rob_pkg::*;

  localparam int PTR_W = (NUM_ENTRIES > 1) ? $clog2(NUM_ENTRIES) : 1;

  logic [PTR_W-1:0] alloc_ptr_q;
  logic [PTR_W-1:0] commit_ptr_q;
  logic [PTR_W:0]   free_cnt_q;

  // depth is a power of two, so the pointers wrap on their own
  always_ff @(posedge clk_i)
  begin
    if (reset_i || flush_i)
    begin
      alloc_ptr_q  <= '0;
      commit_ptr_q <= '0;
      free_cnt_q   <= (PTR_W+1)'(NUM_ENTRIES);
    end
    else
    begin
      if (issue_fire_i)
        alloc_ptr_q <= alloc_ptr_q + 1'b1;
      if (commit_i)
        commit_ptr_q <= commit_ptr_q + 1'b1;
      // issue and commit in the same cycle cancel out
      case ({issue_fire_i, commit_i})
        2'b10:   free_cnt_q <= free_cnt_q - 1'b1;
        2'b01:   free_cnt_q <= free_cnt_q + 1'b1;
        default: free_cnt_q <= free_cnt_q;
      endcase
    end
  end

  assign alloc_tag_o  = rob_tag_t'(alloc_ptr_q);
  assign commit_tag_o = rob_tag_t'(commit_ptr_q);
  assign has_free_o   = (free_cnt_q != '0);
  assign empty_o      = (free_cnt_q == (PTR_W+1)'(NUM_ENTRIES));

  a_free_cnt_range: assert property (@(posedge clk_i) disable iff (reset_i)
    free_cnt_q <= (PTR_W+1)'(NUM_ENTRIES))
    else $error("free count above depth: %0d", free_cnt_q);

  a_no_issue_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    issue_fire_i |-> has_free_o)
    else $error("issue accepted with no free slot");

endmodule

`default_nettype wire

//--- logic/rob_pkg.sv
`default_nettype none

package rob_pkg;

  localparam int TAG_W  = 4;
  localparam int WORD_W = 16;
  localparam int PREG_W = 6;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [TAG_W-1:0]  rob_tag_t;
  typedef logic [PREG_W-1:0] preg_t;

  // architectural condition flags
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // branch conditions, arm style encoding
  typedef enum logic [3:0] {
    EQ = 4'd0,
    NE = 4'd1,
    CS = 4'd2,
    CC = 4'd3,
    MI = 4'd4,
    PL = 4'd5,
    VS = 4'd6,
    VC = 4'd7,
    HI = 4'd8,
    LS = 4'd9,
    GE = 4'd10,
    LT = 4'd11,
    GT = 4'd12,
    LE = 4'd13,
    AL = 4'd14
  } cond_e;

  // what issue hands over for each instruction
  typedef struct packed {
    word_t  pc;
    logic   is_store;
    logic   w_v;
    logic   is_spec;
    logic   is_cond_branch;
    cond_e  bcc_op;
    flags_t flag_mask;
    preg_t  alloc_reg;
    preg_t  freed_reg;
  } issue_entry_t;

  // one slot of the reorder buffer
  typedef struct packed {
    issue_entry_t info;
    logic         wb;
    flags_t       flags;
    word_t        resolved_pc;
  } rob_entry_t;

  // one common data bus lane
  typedef struct packed {
    logic     valid;
    rob_tag_t rob_tag;
    word_t    result;
    flags_t   flags;
  } cdb_t;

  // record for the non-speculative rename table
  typedef struct packed {
    logic  w_v;
    preg_t alloc_reg;
    preg_t freed_reg;
  } commit_rename_t;

  typedef struct packed {
    flags_t mask;
    flags_t value;
  } flag_update_t;

  typedef enum logic {
    CS_SEQUENTIAL   = 1'b0,
    CS_CHECK_TARGET = 1'b1
  } commit_state_e;

endpackage

`default_nettype wire

//--- logic/rob_top.sv
`timescale 1ns/10ps
`default_nettype none

module rob_top #(
  parameter int NUM_ENTRIES = 8,
  parameter int NUM_FU      = 2
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    issue_valid_i,
  input  rob_pkg::issue_entry_t   issue_entry_i,
  output logic                    issue_ready_o,
  output rob_pkg::rob_tag_t       issue_tag_o,
  input  rob_pkg::cdb_t           cdb_i [NUM_FU],
  input  rob_pkg::flags_t         flag_i,
  output logic                    store_pop_o,
  output logic                    preg_free_o,
  output rob_pkg::preg_t          preg_free_num_o,
  output logic                    rename_valid_o,
  output rob_pkg::commit_rename_t rename_entry_o,
  output logic                    flag_valid_o,
  output rob_pkg::flag_update_t   flag_update_o,
  output logic                    mispredict_o,
  output rob_pkg::word_t          redirect_pc_o
);
  import rob_pkg::*;

  rob_tag_t   alloc_tag;
  rob_tag_t   commit_tag;
  logic       has_free;
  logic       empty;
  rob_entry_t head_entry;
  logic       issue_fire;
  logic       do_commit;
  logic       flush;

  assign issue_tag_o = alloc_tag;

  rob_occupancy #(
    .NUM_ENTRIES(NUM_ENTRIES)
  ) i_occupancy (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .issue_fire_i(issue_fire),
    .commit_i    (do_commit),
    .flush_i     (flush),
    .alloc_tag_o (alloc_tag),
    .commit_tag_o(commit_tag),
    .has_free_o  (has_free),
    .empty_o     (empty)
  );

  rob_entry_store #(
    .NUM_ENTRIES(NUM_ENTRIES),
    .NUM_FU     (NUM_FU)
  ) i_entry_store (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .issue_fire_i (issue_fire),
    .issue_entry_i(issue_entry_i),
    .alloc_tag_i  (alloc_tag),
    .cdb_i        (cdb_i),
    .commit_i     (do_commit),
    .commit_tag_i (commit_tag),
    .flush_i      (flush),
    .head_entry_o (head_entry)
  );

  commit_ctrl i_commit_ctrl (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .head_entry_i   (head_entry),
    .empty_i        (empty),
    .has_free_i     (has_free),
    .issue_valid_i  (issue_valid_i),
    .flag_i         (flag_i),
    .issue_ready_o  (issue_ready_o),
    .issue_fire_o   (issue_fire),
    .commit_o       (do_commit),
    .flush_o        (flush),
    .store_pop_o    (store_pop_o),
    .preg_free_o    (preg_free_o),
    .preg_free_num_o(preg_free_num_o),
    .rename_valid_o (rename_valid_o),
    .rename_entry_o (rename_entry_o),
    .flag_valid_o   (flag_valid_o),
    .flag_update_o  (flag_update_o),
    .mispredict_o   (mispredict_o),
    .redirect_pc_o  (redirect_pc_o)
  );

endmodule

`default_nettype wire

//--- testbench/rob_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rob_tb;
  import rob_pkg::*;

  localparam int DEPTH   = 4;
  localparam int NUM_FU  = 2;
  localparam int TIMEOUT = 50;

  typedef logic [$clog2(DEPTH)-1:0] slot_t;

  // one instruction with its writeback data and expected commit record
  typedef struct packed {
    issue_entry_t   entry;
    word_t          result;
    flags_t         wb_flags;
    flags_t         flag_in;
    commit_rename_t exp_rename;
    flag_update_t   exp_flags;
    word_t          exp_next_pc;
  } row_t;

  logic           clk_i;
  logic           reset_i;
  logic           issue_valid_i;
  issue_entry_t   issue_entry_i;
  logic           issue_ready_o;
  rob_tag_t       issue_tag_o;
  cdb_t           cdb [NUM_FU];
  flags_t         flag_i;
  logic           store_pop_o;
  logic           preg_free_o;
  preg_t          preg_free_num_o;
  logic           rename_valid_o;
  commit_rename_t rename_entry_o;
  logic           flag_valid_o;
  flag_update_t   flag_update_o;
  logic           mispredict_o;
  word_t          redirect_pc_o;

  row_t        table_q [$];
  int          inflight_q [$];
  slot_t       tag_of [128];
  logic [31:0] lfsr_q;
  int          b3_start;
  int          b4_start;
  int          b5_start;
  int          errors;
  int          checks;
  int          commits;
  int          flushes;

  // reference model state
  slot_t            m_head;
  slot_t            m_alloc;
  logic [DEPTH-1:0] m_wb;
  logic             m_check;
  word_t            m_exp_pc;

  rob_top #(
    .NUM_ENTRIES(DEPTH),
    .NUM_FU     (NUM_FU)
  ) i_dut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .issue_valid_i  (issue_valid_i),
    .issue_entry_i  (issue_entry_i),
    .issue_ready_o  (issue_ready_o),
    .issue_tag_o    (issue_tag_o),
    .cdb_i          (cdb),
    .flag_i         (flag_i),
    .store_pop_o    (store_pop_o),
    .preg_free_o    (preg_free_o),
    .preg_free_num_o(preg_free_num_o),
    .rename_valid_o (rename_valid_o),
    .rename_entry_o (rename_entry_o),
    .flag_valid_o   (flag_valid_o),
    .flag_update_o  (flag_update_o),
    .mispredict_o   (mispredict_o),
    .redirect_pc_o  (redirect_pc_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic logic cond_holds(input cond_e op, input flags_t f);
    case (op)
      EQ:      return f.z;
      NE:      return !f.z;
      CS:      return f.c;
      CC:      return !f.c;
      MI:      return f.n;
      PL:      return !f.n;
      VS:      return f.v;
      VC:      return !f.v;
      HI:      return f.c && !f.z;
      LS:      return !f.c || f.z;
      GE:      return f.n == f.v;
      LT:      return f.n != f.v;
      GT:      return !f.z && (f.n == f.v);
      LE:      return f.z || (f.n != f.v);
      default: return 1'b1;
    endcase
  endfunction

  // kind 0 is a store, 1 a register write, 2 a register write that sets flags
  function automatic row_t make_plain(input int kind, input word_t pc);
    row_t r;
    r = '0;
    r.entry.pc       = pc;
    r.entry.bcc_op   = AL;
    r.entry.is_store = (kind == 0);
    r.entry.w_v      = (kind != 0);
    if (kind != 0)
    begin
      r.entry.alloc_reg = PREG_W'(take_bits(PREG_W));
      r.entry.freed_reg = PREG_W'(take_bits(PREG_W));
    end
    if (kind == 2)
      r.entry.flag_mask = 4'(take_bits(4) | 32'h1);
    r.result      = WORD_W'(take_bits(WORD_W));
    r.wb_flags    = 4'(take_bits(4));
    r.flag_in     = 4'(take_bits(4));
    r.exp_rename  = '{w_v: r.entry.w_v, alloc_reg: r.entry.alloc_reg,
                      freed_reg: r.entry.freed_reg};
    r.exp_flags   = '{mask: r.entry.flag_mask, value: r.wb_flags};
    r.exp_next_pc = pc + 1'b1;
    return r;
  endfunction

  function automatic row_t make_branch(input word_t pc, input logic is_cond, input cond_e op,
                                       input flags_t fin, input word_t target);
    row_t r;
    r = '0;
    r.entry.pc             = pc;
    r.entry.is_spec        = 1'b1;
    r.entry.is_cond_branch = is_cond;
    r.entry.bcc_op         = op;
    r.result               = target;
    r.wb_flags             = 4'(take_bits(4));
    r.flag_in              = fin;
    if (!is_cond || cond_holds(op, fin))
      r.exp_next_pc = target;
    else
      r.exp_next_pc = pc + 1'b1;
    return r;
  endfunction

  task automatic build_table();
    word_t       pc;
    row_t        r;
    logic [3:0]  f0;
    pc = 16'h0100;
    // plain rows with two unconditional branches
    for (int i = 0; i < 16; i++)
    begin
      if (i == 4 || i == 10)
        r = make_branch(pc, 1'b0, AL, 4'(take_bits(4)), WORD_W'(take_bits(WORD_W)));
      else
        r = make_plain(i % 3, pc);
      table_q.push_back(r);
      pc = r.exp_next_pc;
    end
    b3_start = table_q.size();
    for (int i = 0; i < 5; i++)
    begin
      table_q.push_back(make_plain(i % 3, pc));
      pc = pc + 1'b1;
    end
    // every condition, each with a flag value and its complement
    b4_start = table_q.size();
    for (int k = 0; k < 15; k++)
    begin
      f0 = 4'(take_bits(4));
      for (int s = 0; s < 2; s++)
      begin
        r = make_branch(pc, 1'b1, cond_e'(k), s ? ~f0 : f0, WORD_W'(take_bits(WORD_W)));
        table_q.push_back(r);
        pc = r.exp_next_pc;
        table_q.push_back(make_plain((k + s) % 3, pc));
        pc = pc + 1'b1;
      end
    end
    // branch, wrong successor, extra entry, fresh entry after the flush
    b5_start = table_q.size();
    r = make_branch(pc, 1'b0, AL, 4'(take_bits(4)), 16'h0a00);
    table_q.push_back(r);
    table_q.push_back(make_plain(1, r.exp_next_pc + 16'd5));
    table_q.push_back(make_plain(2, r.exp_next_pc + 16'd6));
    table_q.push_back(make_plain(0, 16'h0c00));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_preg(input string name, input preg_t got, input preg_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_rename(input commit_rename_t got, input commit_rename_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail rename_entry_o: got %h, expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_flags(input flag_update_t got, input flag_update_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail flag_update_o: got %h, expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic end_run();
    $display("checks %0d, errors %0d, commits %0d, flushes %0d",
             checks, errors, commits, flushes);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic timeout_fail(input string msg);
    $display("timeout: %s", msg);
    errors++;
    end_run();
  endtask

  // compare this cycle's outputs, then apply the coming edge to the model
  task automatic model_cycle();
    row_t h;
    logic head_ok;
    logic exp_mis;
    logic exp_commit;
    h = '0;
    if (inflight_q.size() != 0)
      h = table_q[inflight_q[0]];
    head_ok    = (inflight_q.size() != 0) && m_wb[m_head];
    exp_mis    = m_check && head_ok && (h.entry.pc != m_exp_pc);
    exp_commit = head_ok && !exp_mis;
    check_bit("mispredict_o", mispredict_o, exp_mis);
    check_bit("issue_ready_o", issue_ready_o, (inflight_q.size() < DEPTH) && !exp_mis);
    check_bit("store_pop_o", store_pop_o, exp_commit && h.entry.is_store);
    check_bit("preg_free_o", preg_free_o, exp_commit && h.entry.w_v);
    check_bit("rename_valid_o", rename_valid_o, exp_commit);
    check_bit("flag_valid_o", flag_valid_o, exp_commit && (h.exp_flags.mask != '0));
    if (exp_commit)
    begin
      check_rename(rename_entry_o, h.exp_rename);
      if (h.entry.w_v)
        check_preg("preg_free_num_o", preg_free_num_o, h.entry.freed_reg);
      if (h.exp_flags.mask != '0)
        check_flags(flag_update_o, h.exp_flags);
    end
    if (exp_mis)
      check_word("redirect_pc_o", redirect_pc_o, m_exp_pc);
    // flags seen by the head when it commits
    flag_i = h.flag_in;
    if (exp_mis)
    begin
      inflight_q.delete();
      m_head  = '0;
      m_alloc = '0;
      m_wb    = '0;
      m_check = 1'b0;
      flushes++;
    end
    else if (exp_commit)
    begin
      m_check = h.entry.is_spec;
      if (h.entry.is_spec)
        m_exp_pc = h.exp_next_pc;
      m_wb[m_head] = 1'b0;
      m_head = m_head + 1'b1;
      void'(inflight_q.pop_front());
      commits++;
    end
  endtask

  task automatic advance();
    @(negedge clk_i);
    model_cycle();
    issue_valid_i = 1'b0;
    for (int j = 0; j < NUM_FU; j++)
      cdb[j] = '0;
  endtask

  task automatic drive_issue(input int idx, output logic accepted);
    issue_valid_i = 1'b1;
    issue_entry_i = table_q[idx].entry;
    accepted      = issue_ready_o;
    if (accepted)
    begin
      check_tag("issue_tag_o", issue_tag_o, rob_tag_t'(m_alloc));
      tag_of[idx]   = m_alloc;
      m_wb[m_alloc] = 1'b0;
      inflight_q.push_back(idx);
      m_alloc = m_alloc + 1'b1;
    end
  endtask

  task automatic drive_wb(input int idx);
    int lane;
    lane = int'(take_bits(1));
    cdb[lane] = '{valid: 1'b1, rob_tag: rob_tag_t'(tag_of[idx]),
                  result: table_q[idx].result, flags: table_q[idx].wb_flags};
    m_wb[tag_of[idx]] = 1'b1;
  endtask

  task automatic issue_rows(input int first, input int n);
    int   k;
    int   t;
    logic acc;
    k = 0;
    t = 0;
    while (k < n && t < TIMEOUT)
    begin
      advance();
      drive_issue(first + k, acc);
      if (acc)
        k++;
      t++;
    end
    if (k < n)
      timeout_fail("issue did not accept an entry");
  endtask

  task automatic wb_random(input int first, input int n);
    int order [DEPTH];
    int j;
    int tmp;
    for (int i = 0; i < n; i++)
      order[i] = first + i;
    // fisher-yates shuffle
    for (int i = n - 1; i > 0; i--)
    begin
      j        = int'(take_bits(2)) % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < n; i++)
    begin
      advance();
      drive_wb(order[i]);
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (inflight_q.size() != 0 && t < TIMEOUT)
    begin
      advance();
      t++;
    end
    if (inflight_q.size() != 0)
      timeout_fail("buffer did not drain");
  endtask

  task automatic run_batch(input int first);
    issue_rows(first, DEPTH);
    wb_random(first, DEPTH);
    wait_drain();
  endtask

  // fifth entry waits on a full buffer until the head commits
  task automatic backpressure(input int first);
    int   t;
    logic acc;
    issue_rows(first, DEPTH);
    t   = 0;
    acc = 1'b0;
    while (!acc && t < TIMEOUT)
    begin
      advance();
      drive_issue(first + DEPTH, acc);
      if (t == 3)
        drive_wb(first);
      t++;
    end
    if (!acc)
      timeout_fail("held entry was never accepted");
    else
    begin
      wb_random(first + 1, DEPTH);
      wait_drain();
    end
  endtask

  task automatic mispredict_case(input int first);
    int   t;
    int   seen;
    logic acc;
    issue_rows(first, 3);
    advance();
    drive_wb(first + 1);
    advance();
    drive_wb(first);
    t    = 0;
    seen = flushes;
    while (flushes == seen && t < TIMEOUT)
    begin
      advance();
      t++;
    end
    if (flushes == seen)
      timeout_fail("no mispredict after the wrong successor");
    else
    begin
      // buffer is empty again, allocation restarts at slot 0
      advance();
      check_tag("issue_tag_o", issue_tag_o, '0);
      drive_issue(first + 3, acc);
      check_bit("issue accepted after flush", acc, 1'b1);
      advance();
      drive_wb(first + 3);
      wait_drain();
    end
  endtask

  initial
  begin
    lfsr_q        = 32'he4ab;
    errors        = 0;
    checks        = 0;
    commits       = 0;
    flushes       = 0;
    m_head        = '0;
    m_alloc       = '0;
    m_wb          = '0;
    m_check       = 1'b0;
    m_exp_pc      = '0;
    reset_i       = 1'b1;
    issue_valid_i = 1'b0;
    issue_entry_i = '0;
    flag_i        = '0;
    for (int j = 0; j < NUM_FU; j++)
      cdb[j] = '0;
    build_table();
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;
    // idle outputs right after reset
    advance();
    for (int b = 0; b < 4; b++)
      run_batch(b * DEPTH);
    backpressure(b3_start);
    for (int b = 0; b < 15; b++)
      run_batch(b4_start + b * DEPTH);
    mispredict_case(b5_start);
    end_run();
  end

endmodule

`default_nettype wire
